// ==== sim.f ====
+incdir+.
aln_fetch_pkg.sv
aln_ctl_pkg.sv
aln_buf_ptrs.sv
aln_buf_fsm.sv
aln_fetch_queue.sv
aln_extract.sv
aln_top.sv
tb_aln_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the aligner testbench with verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_aln_top -Mdir obj_dir
./obj_dir/Vtb_aln_top | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished without failures"

// ==== tb_aln_top.sv ====
// directed testbench of the instruction aligner against a parcel-stream model
`timescale 1ns/1ns
`include "aln_defines.svh"

module tb_aln_top;
   import aln_fetch_pkg::*;

   // one parcel as the model sees it, fetch type already applied
   typedef struct packed {
      logic [`ALN_PARCEL_W-1:0] data;
      logic [`ALN_PC_W-1:0]     pc;
      logic                     icaf;
      logic [1:0]               icaf_type;
      logic                     dbecc;
      logic                     last;   // ends its fetch
   } parcel_t;

   logic               clk, rst, decode, async_err, flush, consume1, consume2;
   fetch_pkt_t         fetch;
   i0_pkt_t            i0;
   parcel_t            src[$];     // parcels still waiting for fetch
   parcel_t            model[$];   // parcels written into the aligner
   int                 credits, sent, returned, errors, checks;
   logic [31:0]        lcg_state;
   logic [`ALN_PC_W-1:0] next_pc;
   logic               stalled;

   aln_top aln_top_i (
      .clk(clk), .rst(rst), .fetch(fetch), .decode(decode), .async_err(async_err),
      .flush(flush), .i0(i0), .consume1(consume1), .consume2(consume2)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic check(input logic ok, input string msg);
      checks++;
      assert (ok) else begin
         errors++;
         $display("Error at %0t ns: %s", $time, msg);
      end
   endtask

   //**************************************************************************
   // reference model
   //**************************************************************************
   task automatic add_instr(input logic is32, input logic [31:0] bits, input logic [1:0] caf,
                            input logic [1:0] ecc, input logic [1:0] ftype);
      parcel_t p;
      p = '{data: is32 ? {bits[15:2], 2'b11} : {bits[15:1], 1'b0}, pc: next_pc,
            icaf: caf[0], icaf_type: ftype, dbecc: ecc[0], last: 1'b0};
      src.push_back(p);
      next_pc++;
      if (is32) begin   // upper half on the next halfword
         p = '{data: bits[31:16], pc: next_pc, icaf: caf[1], icaf_type: ftype,
               dbecc: ecc[1], last: 1'b0};
         src.push_back(p);
         next_pc++;
      end
   endtask

   // next aligned instruction from the parcels inside the aligner
   function automatic i0_pkt_t expect_i0();
      i0_pkt_t e;
      parcel_t p0, p1;
      e = '0;
      if (model.size() == 0) return e;
      p0 = model[0];
      e.cinst = p0.data;
      e.pc    = p0.pc;
      e.pc4   = (p0.data[1:0] == 2'b11);
      if (!e.pc4) begin
         e.valid     = 1'b1;
         e.instr     = {16'h0000, p0.data};
         e.icaf      = p0.icaf;
         e.dbecc     = p0.dbecc;
         e.icaf_type = p0.icaf_type;
      end else if (model.size() > 1) begin
         p1 = model[1];
         e.valid       = 1'b1;
         e.instr       = {p1.data, p0.data};
         e.icaf        = p0.icaf | p1.icaf;
         e.dbecc       = p0.dbecc | p1.dbecc;
         e.icaf_second = ~(p0.icaf | p0.dbecc) & (p1.icaf | p1.dbecc);
         e.icaf_type   = (p0.icaf | p0.dbecc) ? p0.icaf_type : p1.icaf_type;
      end
      return e;
   endfunction

   // one fetch of n parcels, type of the lower parcel for the whole fetch
   task automatic send_fetch(input int n, output fetch_pkt_t f);
      parcel_t p0, p1;
      f = '0;
      p0 = src.pop_front();
      p0.last     = (n < 2);
      f.val       = 2'b01;
      f.data      = {16'hbeef, p0.data};   // junk upper half
      f.pc        = p0.pc;
      f.icaf      = {1'b0, p0.icaf};
      f.dbecc     = {1'b0, p0.dbecc};
      f.icaf_type = p0.icaf_type;
      model.push_back(p0);
      if (n > 1) begin
         p1 = src.pop_front();
         p1.icaf_type     = p0.icaf_type;
         p1.last          = 1'b1;
         f.val            = 2'b11;
         f.data[31:16]    = p1.data;
         f.icaf[1]        = p1.icaf;
         f.dbecc[1]       = p1.dbecc;
         model.push_back(p1);
      end
   endtask

   // drive at the falling edge, check, then follow the DUT's state
   task automatic run_cycle(input logic want_dec, input int np, input logic do_flush,
                            input logic err);
      i0_pkt_t    exp;
      fetch_pkt_t f;
      logic       take;
      int         n;
      int         freed;
      @(negedge clk);
      exp = expect_i0();
      check(i0.valid == exp.valid,
            $sformatf("i0.valid is %b, expected %b", i0.valid, exp.valid));
      take = want_dec & i0.valid & ~do_flush;
      if (take && !stalled) begin
         check(i0 == exp, $sformatf("i0 is %h, expected %h", i0, exp));
      end
      // fetch buffers emptied by the instruction taken now
      freed = 0;
      if (take && !stalled && exp.valid) begin
         freed = int'(model[0].last);
         if (exp.pc4) freed += int'(model[1].last);
      end
      n = (np > src.size()) ? src.size() : np;
      f = '0;
      if (credits > 0 && n > 0 && !do_flush) send_fetch(n, f);
      fetch     = f;
      decode    = take;
      flush     = do_flush;
      async_err = err;
      #1;
      check(int'(consume1) + 2 * int'(consume2) == freed,
            $sformatf("consume returned %0d buffers, expected %0d",
                      int'(consume1) + 2 * int'(consume2), freed));
      if (f.val[0]) begin
         credits--;
         sent++;
      end
      if (consume1) credits++;
      if (consume2) credits += 2;
      returned += int'(consume1) + 2 * int'(consume2);
      check(credits >= 0 && credits <= 3, $sformatf("credit count is %0d", credits));
      if (take && !stalled) begin
         void'(model.pop_front());
         if (exp.pc4) void'(model.pop_front());
      end
      if (err) stalled = 1'b1;
      if (do_flush) begin
         model.delete();
         src.delete();
         credits  = 3;
         sent     = 0;
         returned = 0;
         stalled  = 1'b0;
      end
   endtask

   task automatic drain(input logic rnd);
      int   t;
      int   np;
      logic dec;
      t = 0;
      while ((src.size() > 0 || model.size() > 0) && t < 300) begin
         dec = rnd ? (((lcg_next() >> 16) & 32'd3) != 0) : 1'b1;
         np  = rnd ? 1 + int'((lcg_next() >> 16) & 32'd1) : 2;
         run_cycle(dec, np, 1'b0, 1'b0);
         t++;
      end
      if (src.size() > 0 || model.size() > 0) begin
         errors++;
         $display("Timeout: the instruction stream did not drain within 300 cycles");
      end
      check(sent == returned, $sformatf("%0d credits returned for %0d fetches", returned, sent));
   endtask

   //**************************************************************************
   // directed tests
   //**************************************************************************
   task automatic after_reset();
      run_cycle(1'b0, 0, 1'b0, 1'b0);
      check(!i0.valid && credits == 3, "aligner not idle after reset");
   endtask

   task automatic aligned_stream();
      for (int k = 0; k < 6; k++) add_instr(1'b1, 32'h0000_0013 + k * 32'h0001_0100, 0, 0, 0);
      drain(1'b0);
   endtask

   task automatic random_mix();
      logic [31:0] r;
      for (int k = 0; k < 40; k++) begin
         r = lcg_next();
         add_instr(r[31], lcg_next(), 2'b00, 2'b00, 2'b00);
      end
      drain(1'b1);
   endtask

   task automatic back_pressure();
      i0_pkt_t held;
      int      base;
      base = sent;
      for (int k = 0; k < 8; k++) add_instr(1'b1, 32'h0bad_0000 + k * 4, 0, 0, 0);
      run_cycle(1'b0, 2, 1'b0, 1'b0);
      run_cycle(1'b0, 2, 1'b0, 1'b0);
      held = i0;
      repeat (8) begin
         run_cycle(1'b0, 2, 1'b0, 1'b0);
         check(i0 == held, "i0 changed while decode was held low");
      end
      check(sent - base == 3 && credits == 0, $sformatf("%0d fetches sent", sent - base));
      drain(1'b0);
   endtask

   task automatic flush_and_stall();
      i0_pkt_t held;
      for (int k = 0; k < 8; k++) add_instr(k[0], 32'h0731_2a00 + k * 8, 0, 0, 0);
      repeat (3) run_cycle(1'b1, 2, 1'b0, 1'b0);
      run_cycle(1'b0, 0, 1'b0, 1'b1);   // stall from the next edge
      held = i0;
      repeat (4) begin
         run_cycle(1'b1, 0, 1'b0, 1'b0);
         check(i0 == held, "i0 changed during the error stall");
      end
      run_cycle(1'b0, 0, 1'b1, 1'b0);
      run_cycle(1'b0, 0, 1'b0, 1'b0);
      check(!i0.valid && credits == 3, "aligner not idle after flush");
      next_pc = 31'h2000_1a40;          // unrelated restart pc
      for (int k = 0; k < 5; k++) add_instr(k[1], 32'h00a5_5a00 + k * 16, 0, 0, 0);
      drain(1'b0);
   endtask

   // two 32b instructions straddle fetch boundaries with a bad upper half
   task automatic fault_flags();
      add_instr(1'b0, 32'h0000_4a5c, 2'b01, 2'b00, 2'b10);
      add_instr(1'b0, 32'h0000_1234, 2'b00, 2'b00, 2'b10);
      add_instr(1'b0, 32'h0000_5678, 2'b00, 2'b00, 2'b10);
      add_instr(1'b1, 32'h00c1_2083, 2'b10, 2'b00, 2'b01);
      add_instr(1'b1, 32'h0041_8193, 2'b00, 2'b10, 2'b11);
      add_instr(1'b0, 32'h0000_6e20, 2'b00, 2'b01, 2'b11);
      drain(1'b0);
   endtask

   initial begin
      lcg_state = 32'd93293;
      errors    = 0;
      checks    = 0;
      credits   = 3;
      sent      = 0;
      returned  = 0;
      stalled   = 1'b0;
      next_pc   = 31'h0000_0100;
      rst       = 1'b1;
      fetch     = '0;
      decode    = 1'b0;
      async_err = 1'b0;
      flush     = 1'b0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      after_reset();
      aligned_stream();
      random_mix();
      back_pressure();
      flush_and_stall();
      fault_flags();
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== aln_top.sv ====
// instruction aligner top level: pointers, occupancy control, queue, extractor
`timescale 1ns/1ns
`include "aln_defines.svh"

module aln_top (
   input  logic                      clk,
   input  logic                      rst,
   input  aln_fetch_pkg::fetch_pkt_t fetch,
   input  logic                      decode,
   input  logic                      async_err,
   input  logic                      flush,
   output aln_fetch_pkg::i0_pkt_t    i0,
   output logic                      consume1,
   output logic                      consume2
);
   import aln_fetch_pkg::*;
   import aln_ctl_pkg::*;

   logic [`ALN_NUM_BUF-1:0] wr_en;
   buf_ptr_t                rd_ptr;
   logic [1:0]              f0val, f1val;
   logic                    f0_shift_2b, f1_shift_2b;
   qwin_t                   win;
   instr_len_e              instr_len;

   aln_buf_ptrs ptrs_i (
      .clk(clk), .rst(rst), .fetch_valid(fetch.val[0]),
      .consume1(consume1), .consume2(consume2), .flush(flush),
      .wr_en(wr_en), .rd_ptr(rd_ptr)
   );

   aln_buf_fsm fsm_i (
      .clk(clk), .rst(rst), .fetch_val(fetch.val), .decode(decode),
      .instr_len(instr_len), .async_err(async_err), .flush(flush),
      .f0val(f0val), .f1val(f1val), .f0_shift_2b(f0_shift_2b), .f1_shift_2b(f1_shift_2b),
      .consume1(consume1), .consume2(consume2)
   );

   aln_fetch_queue queue_i (
      .clk(clk), .rst(rst), .fetch(fetch), .wr_en(wr_en), .rd_ptr(rd_ptr),
      .f0_shift_2b(f0_shift_2b), .f1_shift_2b(f1_shift_2b), .win(win)
   );

   aln_extract extract_i (
      .win(win), .f0val(f0val), .f1val(f1val), .i0(i0), .instr_len(instr_len)
   );

endmodule

// ==== aln_extract.sv ====
// parcel alignment, length detection and fault marking of the next instruction
`timescale 1ns/1ns

module aln_extract (
   input  aln_ctl_pkg::qwin_t         win,
   input  logic [1:0]                 f0val,
   input  logic [1:0]                 f1val,
   output aln_fetch_pkg::i0_pkt_t     i0,
   output aln_fetch_pkg::instr_len_e  instr_len
);
   import aln_fetch_pkg::*;

   logic [31:0] aligndata;
   logic [1:0]  alignval;
   logic [1:0]  alignicaf;
   logic [1:0]  aligndbecc;
   logic [1:0]  icaf_eff;
   logic        straddle;   // f0 holds one parcel, rest comes from f1
   logic        first4b;

   assign straddle = ~f0val[1] & f0val[0];

   always_comb begin
      if (f0val[1]) begin
         aligndata  = win.f0_data;
         alignval   = 2'b11;
         alignicaf  = win.f0_icaf;
         aligndbecc = win.f0_dbecc;
      end else if (f0val[0]) begin
         aligndata  = {win.f1_parcel, win.f0_data[15:0]};
         alignval   = {f1val[0], 1'b1};
         alignicaf  = {win.f1_icaf[0], win.f0_icaf[0]};
         aligndbecc = {win.f1_dbecc[0], win.f0_dbecc[0]};
      end else begin
         aligndata  = '0;
         alignval   = 2'b00;
         alignicaf  = 2'b00;
         aligndbecc = 2'b00;
      end
   end

   assign instr_len = (aligndata[1:0] == 2'b11) ? LEN_32 : LEN_16;
   assign first4b   = (instr_len == LEN_32);
   assign icaf_eff  = alignicaf | aligndbecc;

   //**************************************************************************
   // i0 packet
   //**************************************************************************
   always_comb begin
      i0.valid = first4b ? alignval[1] : alignval[0];
      if (!i0.valid) begin
         i0.instr = '0;
      end else if (first4b) begin
         i0.instr = aligndata;
      end else begin
         i0.instr = {16'b0, aligndata[15:0]};   // no decompression here
      end
      i0.cinst       = aligndata[15:0];
      i0.pc          = win.f0_pc;
      i0.pc4         = first4b;
      // any faulty parcel of the instruction marks it
      i0.icaf        = first4b ? |alignicaf : alignicaf[0];
      i0.dbecc       = first4b ? |aligndbecc : aligndbecc[0];
      i0.icaf_second = first4b & ~icaf_eff[0] & icaf_eff[1];
      // fault type of the second fetch when only its half is bad
      i0.icaf_type   = (first4b & straddle & ~icaf_eff[0]) ? win.f1_icaf_type :
                                                             win.f0_icaf_type;
   end

endmodule

// ==== aln_fetch_queue.sv ====
// three-entry fetch queue with half-consumed offsets and rotated f0/f1 window
`timescale 1ns/1ns
`include "aln_defines.svh"

module aln_fetch_queue (
   input  logic                      clk,
   input  logic                      rst,
   input  aln_fetch_pkg::fetch_pkt_t fetch,
   input  logic [`ALN_NUM_BUF-1:0]   wr_en,
   input  aln_ctl_pkg::buf_ptr_t     rd_ptr,
   input  logic                      f0_shift_2b,
   input  logic                      f1_shift_2b,
   output aln_ctl_pkg::qwin_t        win
);
   import aln_ctl_pkg::*;

   logic [`ALN_FETCH_W-1:0] q_data  [`ALN_NUM_BUF];
   logic [`ALN_PC_W-1:0]    q_pc    [`ALN_NUM_BUF];
   logic [1:0]              q_icaf  [`ALN_NUM_BUF];
   logic [1:0]              q_type  [`ALN_NUM_BUF];
   logic [1:0]              q_dbecc [`ALN_NUM_BUF];
   logic [`ALN_NUM_BUF-1:0] q_off;   // lower parcel already used
   buf_ptr_t                f0_idx, f1_idx;
   logic                    f0_off, f1_off;

   // per-parcel flags once the lower parcel is gone
   function automatic logic [1:0] drop_lo(input logic [1:0] flags, input logic off);
      return off ? {1'b0, flags[1]} : flags;
   endfunction

   always_ff @(posedge clk) begin
      for (int i = 0; i < `ALN_NUM_BUF; i++) begin
         if (wr_en[i]) begin
            q_data[i]  <= fetch.data;
            q_pc[i]    <= fetch.pc;
            q_icaf[i]  <= fetch.icaf;
            q_type[i]  <= fetch.icaf_type;
            q_dbecc[i] <= fetch.dbecc;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         q_off <= '0;
      end else begin
         for (int i = 0; i < `ALN_NUM_BUF; i++) begin
            if (wr_en[i]) begin
               q_off[i] <= 1'b0;                       // fresh fetch
            end else if (buf_ptr_t'(i) == f0_idx) begin
               q_off[i] <= q_off[i] | f0_shift_2b;
            end else if (buf_ptr_t'(i) == f1_idx) begin
               q_off[i] <= q_off[i] | f1_shift_2b;     // straddled half taken
            end
         end
      end
   end

   //**************************************************************************
   // rotate by rd_ptr into the f0/f1 view
   //**************************************************************************
   assign f0_idx = rd_ptr;
   assign f1_idx = (rd_ptr == buf_ptr_t'(`ALN_NUM_BUF - 1)) ? '0 : rd_ptr + 1'b1;
   assign f0_off = q_off[f0_idx];
   assign f1_off = q_off[f1_idx];

   always_comb begin
      win.f0_data = f0_off ?
                    {{`ALN_PARCEL_W{1'b0}}, q_data[f0_idx][`ALN_FETCH_W-1:`ALN_PARCEL_W]} :
                    q_data[f0_idx];
      win.f1_parcel = f1_off ? q_data[f1_idx][`ALN_FETCH_W-1:`ALN_PARCEL_W] :
                               q_data[f1_idx][`ALN_PARCEL_W-1:0];
      win.f0_pc        = q_pc[f0_idx] + `ALN_PC_W'(f0_off); // one halfword on
      win.f1_pc        = q_pc[f1_idx] + `ALN_PC_W'(f1_off);
      win.f0_icaf      = drop_lo(q_icaf[f0_idx], f0_off);
      win.f1_icaf      = drop_lo(q_icaf[f1_idx], f1_off);
      win.f0_dbecc     = drop_lo(q_dbecc[f0_idx], f0_off);
      win.f1_dbecc     = drop_lo(q_dbecc[f1_idx], f1_off);
      win.f0_icaf_type = q_type[f0_idx];
      win.f1_icaf_type = q_type[f1_idx];
   end

endmodule

// ==== aln_buf_fsm.sv ====
// occupancy control of buffers f0/f1/f2 with error stall and consume returns
`timescale 1ns/1ns

module aln_buf_fsm (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [1:0]                fetch_val,
   input  logic                      decode,
   input  aln_fetch_pkg::instr_len_e instr_len,
   input  logic                      async_err,
   input  logic                      flush,
   output logic [1:0]                f0val,
   output logic [1:0]                f1val,
   output logic                      f0_shift_2b,
   output logic                      f1_shift_2b,
   output logic                      consume1,
   output logic                      consume2
);
   import aln_fetch_pkg::*;
   import aln_ctl_pkg::*;

   logic [1:0] f2val;
   logic [1:0] sf0val, sf1val;   // valids after this cycle's shift
   logic [1:0] f0val_in, f1val_in, f2val_in;
   logic       error_stall;
   logic       i0_shift, shift_2b, shift_4b;
   logic       consume_fb0, consume_fb1;
   logic       shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic       fetch_to_f0, fetch_to_f1, fetch_to_f2;
   fill_e      fill;

   //**************************************************************************
   // instruction shift out of f0/f1
   //**************************************************************************
   assign i0_shift = decode & ~error_stall;
   assign shift_2b = i0_shift & (instr_len == LEN_16);
   assign shift_4b = i0_shift & (instr_len == LEN_32);

   assign f0_shift_2b = (shift_2b & f0val[0]) | (shift_4b & f0val[0] & ~f0val[1]);
   assign f1_shift_2b = shift_4b & f0val[0] & ~f0val[1]; // straddling 4B

   assign sf0val = shift_4b ? 2'b00 : (shift_2b ? {1'b0, f0val[1]} : f0val);
   assign sf1val = f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   // buffer fully drained this cycle
   assign consume_fb0 = ~sf0val[0] & f0val[0];
   assign consume_fb1 = ~sf1val[0] & f1val[0];
   assign consume1    = consume_fb0 & ~consume_fb1 & ~flush;
   assign consume2    = consume_fb0 & consume_fb1 & ~flush;

   //**************************************************************************
   // compaction and fetch placement
   //**************************************************************************
   assign shift_f1_f0 = ~sf0val[0] & sf1val[0];
   assign shift_f2_f0 = ~sf0val[0] & ~sf1val[0] & f2val[0];
   assign shift_f2_f1 = ~sf0val[0] & sf1val[0] & f2val[0];

   always_comb begin
      case ({sf0val[0], sf1val[0], f2val[0]})
         3'b000:                 fill = FILL_EMPTY;
         3'b100, 3'b010, 3'b001: fill = FILL_F0;
         3'b110, 3'b011:         fill = FILL_F0F1;
         default:                fill = FILL_ALL;
      endcase
   end

   assign fetch_to_f0 = fetch_val[0] & (fill == FILL_EMPTY);
   assign fetch_to_f1 = fetch_val[0] & (fill == FILL_F0);
   assign fetch_to_f2 = fetch_val[0] & (fill == FILL_F0F1);

   always_comb begin
      if (flush) begin
         f0val_in = 2'b00;
         f1val_in = 2'b00;
         f2val_in = 2'b00;
      end else begin
         f0val_in = fetch_to_f0 ? fetch_val :
                    shift_f2_f0 ? f2val :
                    shift_f1_f0 ? sf1val : sf0val;
         f1val_in = fetch_to_f1 ? fetch_val :
                    shift_f2_f1 ? f2val :
                    shift_f1_f0 ? 2'b00 : sf1val;
         f2val_in = fetch_to_f2 ? fetch_val :
                    (shift_f2_f1 | shift_f2_f0) ? 2'b00 : f2val;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         f0val       <= 2'b00;
         f1val       <= 2'b00;
         f2val       <= 2'b00;
         error_stall <= 1'b0;
      end else begin
         f0val       <= f0val_in;
         f1val       <= f1val_in;
         f2val       <= f2val_in;
         error_stall <= (error_stall | async_err) & ~flush; // held until flush
      end
   end

endmodule

// ==== aln_buf_ptrs.sv ====
// fetch buffer write and read pointers, counting modulo the buffer depth
`timescale 1ns/1ns
`include "aln_defines.svh"

module aln_buf_ptrs (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    fetch_valid,
   input  logic                    consume1,
   input  logic                    consume2,
   input  logic                    flush,
   output logic [`ALN_NUM_BUF-1:0] wr_en,
   output aln_ctl_pkg::buf_ptr_t   rd_ptr
);
   import aln_ctl_pkg::*;

   buf_ptr_t wr_ptr;

   // step a pointer by one or two entries with wrap
   function automatic buf_ptr_t ptr_add(input buf_ptr_t ptr, input logic [1:0] step);
      logic [2:0] sum;
      sum = ptr + step;
      if (sum >= 3'(`ALN_NUM_BUF)) begin
         sum = sum - 3'(`ALN_NUM_BUF);
      end
      return buf_ptr_t'(sum);
   endfunction

   // one-hot write enable of the entry under the write pointer
   always_comb begin
      wr_en = '0;
      wr_en[wr_ptr] = fetch_valid;
   end

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (fetch_valid) begin
            wr_ptr <= ptr_add(wr_ptr, 2'd1);
         end
         if (consume2) begin
            rd_ptr <= ptr_add(rd_ptr, 2'd2); // f0 and f1 both freed
         end else if (consume1) begin
            rd_ptr <= ptr_add(rd_ptr, 2'd1);
         end
      end
   end

endmodule

// ==== aln_ctl_pkg.sv ====
// control types of the aligner: buffer pointers, fill state, read window
`include "aln_defines.svh"

package aln_ctl_pkg;

   typedef logic [$clog2(`ALN_NUM_BUF)-1:0] buf_ptr_t;

   // occupancy after compaction, later buffers never valid ahead of earlier ones
   typedef enum logic [1:0] {
      FILL_EMPTY,
      FILL_F0,
      FILL_F0F1,
      FILL_ALL
   } fill_e;

   // f0/f1 view of the queue, offsets already applied
   typedef struct packed {
      logic [`ALN_FETCH_W-1:0]  f0_data;
      logic [`ALN_PARCEL_W-1:0] f1_parcel; // next parcel after f0
      logic [`ALN_PC_W-1:0]     f0_pc;
      logic [`ALN_PC_W-1:0]     f1_pc;
      logic [1:0]               f0_icaf;
      logic [1:0]               f1_icaf;
      logic [1:0]               f0_dbecc;
      logic [1:0]               f1_dbecc;
      logic [1:0]               f0_icaf_type;
      logic [1:0]               f1_icaf_type;
   } qwin_t;

endpackage

// ==== aln_fetch_pkg.sv ====
// fetch-side and decode-side packet types of the instruction aligner
`include "aln_defines.svh"

package aln_fetch_pkg;

   // one fetch from the ifu, parcel flags right justified
   typedef struct packed {
      logic [1:0]              val;       // parcel valids
      logic [`ALN_FETCH_W-1:0] data;      // memory format
      logic [`ALN_PC_W-1:0]    pc;        // pc of lower parcel
      logic [1:0]              icaf;      // access fault per parcel
      logic [1:0]              icaf_type; // one per fetch
      logic [1:0]              dbecc;     // double-bit ecc per parcel
   } fetch_pkt_t;

   // instruction handed to decode
   typedef struct packed {
      logic                     valid;
      logic [`ALN_FETCH_W-1:0]  instr;       // 16b parcels zero extended
      logic [`ALN_PARCEL_W-1:0] cinst;       // raw low parcel
      logic [`ALN_PC_W-1:0]     pc;
      logic                     pc4;         // 32-bit instruction
      logic                     icaf;
      logic [1:0]               icaf_type;
      logic                     icaf_second; // fault on upper half only
      logic                     dbecc;
   } i0_pkt_t;

   // low two bits 2'b11 mark a 32-bit instruction
   typedef enum logic {
      LEN_16 = 1'b0,
      LEN_32 = 1'b1
   } instr_len_e;

endpackage

// ==== aln_defines.svh ====
// aligner sizing macros for parcel, fetch and pc widths and buffer depth
`ifndef ALN_DEFINES_SVH
`define ALN_DEFINES_SVH

// one 16-bit instruction parcel
`define ALN_PARCEL_W 16

// one fetch carries two parcels
`define ALN_FETCH_W 32

// halfword pc, bits 31 down to 1
`define ALN_PC_W 31

// entries in the circular fetch buffer
`define ALN_NUM_BUF 3

`endif
